// ==== source/ex_pkg.sv ====
`default_nettype none

package ex_pkg;

    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [13:0] csr_addr_t;
    typedef logic [5:0]  alu_op_t;
    typedef logic [2:0]  alu_sel_t;
    typedef logic [8:0]  excp_num_t;
    typedef logic [9:0]  excp_code_t;

    // operation codes
    localparam alu_op_t OP_OR      = 6'h01;
    localparam alu_op_t OP_AND     = 6'h02;
    localparam alu_op_t OP_XOR     = 6'h03;
    localparam alu_op_t OP_NOR     = 6'h04;
    localparam alu_op_t OP_SLL     = 6'h05;
    localparam alu_op_t OP_SRL     = 6'h06;
    localparam alu_op_t OP_SRA     = 6'h07;
    localparam alu_op_t OP_ADD     = 6'h08;
    localparam alu_op_t OP_SUB     = 6'h09;
    localparam alu_op_t OP_SLT     = 6'h0a;
    localparam alu_op_t OP_SLTU    = 6'h0b;
    localparam alu_op_t OP_MUL     = 6'h0c;
    localparam alu_op_t OP_MULH    = 6'h0d;
    localparam alu_op_t OP_MULHU   = 6'h0e;
    localparam alu_op_t OP_LUI     = 6'h0f;
    localparam alu_op_t OP_PCADD   = 6'h10;
    localparam alu_op_t OP_B       = 6'h11;
    localparam alu_op_t OP_BL      = 6'h12;
    localparam alu_op_t OP_JIRL    = 6'h13;
    localparam alu_op_t OP_BEQ     = 6'h14;
    localparam alu_op_t OP_BNE     = 6'h15;
    localparam alu_op_t OP_BLT     = 6'h16;
    localparam alu_op_t OP_BGE     = 6'h17;
    localparam alu_op_t OP_BLTU    = 6'h18;
    localparam alu_op_t OP_BGEU    = 6'h19;
    localparam alu_op_t OP_CSRRD   = 6'h1a;
    localparam alu_op_t OP_CSRWR   = 6'h1b;
    localparam alu_op_t OP_CSRXCHG = 6'h1c;

    // result groups, zero selects nothing
    localparam alu_sel_t SEL_LOGIC = 3'd1;
    localparam alu_sel_t SEL_SHIFT = 3'd2;
    localparam alu_sel_t SEL_MOVE  = 3'd3;
    localparam alu_sel_t SEL_ARITH = 3'd4;
    localparam alu_sel_t SEL_JUMP  = 3'd5;
    localparam alu_sel_t SEL_CSR   = 3'd6;

    localparam csr_addr_t CSR_CRMD  = 14'h0;
    localparam csr_addr_t CSR_PRMD  = 14'h1;
    localparam csr_addr_t CSR_ERA   = 14'h6;
    localparam csr_addr_t CSR_SAVE0 = 14'h30;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } instr_info_t;

    typedef struct packed {
        logic      we;
        csr_addr_t addr;
        word_t     data;
    } csr_write_t;

    // comparisons made in dispatch
    typedef struct packed {
        logic eq;
        logic ne;
        logic lt;
        logic ge;
        logic ltu;
        logic geu;
    } branch_cmp_t;

    typedef struct packed {
        instr_info_t instr_info;
        alu_op_t     aluop;
        alu_sel_t    alusel;
        word_t       oprand1;
        word_t       oprand2;
        word_t       imm;
        logic        reg_write_valid;
        reg_addr_t   reg_write_addr;
        csr_write_t  csr_signal;
        branch_cmp_t branch_cmp;
    } dispatch_ex_t;

    typedef struct packed {
        instr_info_t instr_info;
        alu_op_t     aluop;
        logic        wreg;
        reg_addr_t   waddr;
        word_t       wdata;
        word_t       mem_addr;
        word_t       reg2;
        csr_write_t  csr_signal;
    } ex_mem_t;

    typedef struct packed {
        logic      wreg;
        reg_addr_t waddr;
        word_t     wdata;
        alu_op_t   aluop;
    } ex_fwd_t;

endpackage

`default_nettype wire

// ==== source/ex_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module ex_alu (
    input  wire ex_pkg::alu_op_t  aluop_i,
    input  wire ex_pkg::alu_sel_t alusel_i,
    input  wire ex_pkg::word_t    oprand1_i,
    input  wire ex_pkg::word_t    oprand2_i,
    input  wire ex_pkg::word_t    pc_i,
    input  wire ex_pkg::word_t    csr_rdata_i,
    output ex_pkg::word_t         wdata_o
);

    ex_pkg::word_t logic_res;
    ex_pkg::word_t shift_res;
    ex_pkg::word_t move_res;
    ex_pkg::word_t arith_res;
    logic [4:0] shamt;

    logic mul_signed;
    logic signed [32:0] mul_a;
    logic signed [32:0] mul_b;
    logic signed [65:0] mul_full;
    ex_pkg::dword_t mul_res;

    assign shamt = oprand2_i[4:0];

    // one 33x33 multiplier, top bit is the sign only for MULH
    assign mul_signed = (aluop_i == ex_pkg::OP_MULH);
    assign mul_a      = {mul_signed & oprand1_i[31], oprand1_i};
    assign mul_b      = {mul_signed & oprand2_i[31], oprand2_i};
    assign mul_full   = mul_a * mul_b;
    assign mul_res    = mul_full[63:0];

    always_comb begin
        case (aluop_i)
            ex_pkg::OP_OR:  logic_res = oprand1_i | oprand2_i;
            ex_pkg::OP_AND: logic_res = oprand1_i & oprand2_i;
            ex_pkg::OP_XOR: logic_res = oprand1_i ^ oprand2_i;
            ex_pkg::OP_NOR: logic_res = ~(oprand1_i | oprand2_i);
            default:        logic_res = '0;
        endcase
    end

    always_comb begin
        case (aluop_i)
            ex_pkg::OP_SLL: shift_res = oprand1_i << shamt;
            ex_pkg::OP_SRL: shift_res = oprand1_i >> shamt;
            // sign fill
            ex_pkg::OP_SRA: shift_res = ex_pkg::word_t'($signed(oprand1_i) >>> shamt);
            default:        shift_res = '0;
        endcase
    end

    always_comb begin
        case (aluop_i)
            ex_pkg::OP_LUI:   move_res = oprand2_i;
            ex_pkg::OP_PCADD: move_res = oprand2_i + pc_i;
            default:          move_res = '0;
        endcase
    end

    always_comb begin
        arith_res = '0;
        case (aluop_i)
            ex_pkg::OP_ADD:   arith_res = oprand1_i + oprand2_i;
            ex_pkg::OP_SUB:   arith_res = oprand1_i - oprand2_i;
            ex_pkg::OP_SLT:   arith_res[0] = $signed(oprand1_i) < $signed(oprand2_i);
            ex_pkg::OP_SLTU:  arith_res[0] = oprand1_i < oprand2_i;
            ex_pkg::OP_MUL:   arith_res = mul_res[31:0];
            ex_pkg::OP_MULH,
            ex_pkg::OP_MULHU: arith_res = mul_res[63:32];
            default:          arith_res = '0;
        endcase
    end

    // result select
    always_comb begin
        case (alusel_i)
            ex_pkg::SEL_LOGIC: wdata_o = logic_res;
            ex_pkg::SEL_SHIFT: wdata_o = shift_res;
            ex_pkg::SEL_MOVE:  wdata_o = move_res;
            ex_pkg::SEL_ARITH: wdata_o = arith_res;
            // link value
            ex_pkg::SEL_JUMP:  wdata_o = pc_i + 32'd4;
            ex_pkg::SEL_CSR:   wdata_o = csr_rdata_i;
            default:           wdata_o = '0;
        endcase
    end

    // group code comes straight from dispatch
    always_comb begin
        a_sel_known: assert (!$isunknown(alusel_i))
            else $error("alusel_i is unknown");
    end

endmodule

`default_nettype wire

// ==== source/ex_branch.sv ====
`timescale 1ns/100ps
`default_nettype none

module ex_branch (
    input  wire                      en_i,
    input  wire ex_pkg::alu_op_t     aluop_i,
    input  wire ex_pkg::word_t       pc_i,
    input  wire ex_pkg::word_t       imm_i,
    input  wire ex_pkg::word_t       oprand1_i,
    input  wire ex_pkg::branch_cmp_t branch_cmp_i,
    output logic                     branch_flag_o,
    output ex_pkg::word_t            branch_target_o
);

    logic taken;

    always_comb begin
        taken           = 1'b0;
        branch_target_o = pc_i + imm_i;
        case (aluop_i)
            ex_pkg::OP_B,
            ex_pkg::OP_BL: begin
                taken = 1'b1;
            end
            // register indirect
            ex_pkg::OP_JIRL: begin
                taken           = 1'b1;
                branch_target_o = oprand1_i + imm_i;
            end
            ex_pkg::OP_BEQ:  taken = branch_cmp_i.eq;
            ex_pkg::OP_BNE:  taken = branch_cmp_i.ne;
            ex_pkg::OP_BLT:  taken = branch_cmp_i.lt;
            ex_pkg::OP_BGE:  taken = branch_cmp_i.ge;
            ex_pkg::OP_BLTU: taken = branch_cmp_i.ltu;
            ex_pkg::OP_BGEU: taken = branch_cmp_i.geu;
            default: begin
                taken = 1'b0;
            end
        endcase
    end

    assign branch_flag_o = en_i & taken;

endmodule

`default_nettype wire

// ==== source/ex_csr_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module ex_csr_file #(
    parameter int NUM_SAVE = 2
) (
    input  wire                    clk_i,
    input  wire                    rst_n_i,
    input  wire ex_pkg::csr_addr_t addr_i,
    input  wire                    we_i,
    input  wire                    xchg_i,
    input  wire ex_pkg::word_t     wdata_i,
    input  wire ex_pkg::word_t     mask_i,
    output ex_pkg::word_t          rdata_o
);

    if (NUM_SAVE < 1 || NUM_SAVE > 4) begin : g_bad_num_save
        $error("NUM_SAVE must be 1 to 4");
    end

    ex_pkg::word_t crmd_q;
    ex_pkg::word_t prmd_q;
    ex_pkg::word_t era_q;
    ex_pkg::word_t [NUM_SAVE-1:0] save_q;

    logic hit_crmd;
    logic hit_prmd;
    logic hit_era;
    logic [NUM_SAVE-1:0] hit_save;
    logic mapped;
    ex_pkg::word_t new_val;

    assign hit_crmd = (addr_i == ex_pkg::CSR_CRMD);
    assign hit_prmd = (addr_i == ex_pkg::CSR_PRMD);
    assign hit_era  = (addr_i == ex_pkg::CSR_ERA);

    always_comb begin
        for (int i = 0; i < NUM_SAVE; i++) begin
            hit_save[i] = (addr_i == ex_pkg::CSR_SAVE0 + ex_pkg::csr_addr_t'(i));
        end
    end

    assign mapped = hit_crmd | hit_prmd | hit_era | (|hit_save);

    always_comb begin
        rdata_o = '0;
        if (hit_crmd) rdata_o = crmd_q;
        if (hit_prmd) rdata_o = prmd_q;
        if (hit_era)  rdata_o = era_q;
        for (int i = 0; i < NUM_SAVE; i++) begin
            if (hit_save[i]) rdata_o = save_q[i];
        end
    end

    // xchg keeps old bits outside the mask
    assign new_val = xchg_i ? ((wdata_i & mask_i) | (rdata_o & ~mask_i)) : wdata_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            crmd_q <= 32'h8;
            prmd_q <= '0;
            era_q  <= '0;
            save_q <= '0;
        end else if (we_i) begin
            if (hit_crmd) crmd_q <= new_val;
            if (hit_prmd) prmd_q <= new_val;
            if (hit_era)  era_q  <= new_val;
            for (int i = 0; i < NUM_SAVE; i++) begin
                if (hit_save[i]) save_q[i] <= new_val;
            end
        end
    end

    // decode must not issue a write to a hole in the map
    a_we_mapped: assert property (@(posedge clk_i) disable iff (!rst_n_i) we_i |-> mapped)
        else $error("CSR write to unmapped address %h", addr_i);

endmodule

`default_nettype wire

// ==== source/ex_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module ex_stage #(
    parameter int NUM_SAVE = 2
) (
    input  wire                       clk_i,
    input  wire                       rst_n_i,
    input  wire ex_pkg::dispatch_ex_t dispatch_i,
    input  wire                       excp_i,
    input  wire ex_pkg::excp_num_t    excp_num_i,
    input  wire                       stall_i,
    output ex_pkg::ex_mem_t           ex_o,
    output ex_pkg::ex_fwd_t           ex_fwd_o,
    output logic                      branch_flag_o,
    output ex_pkg::word_t             branch_target_o,
    output logic                      excp_o,
    output ex_pkg::excp_code_t        excp_code_o
);

    ex_pkg::word_t alu_wdata;
    ex_pkg::word_t csr_rdata;
    ex_pkg::word_t br_target;
    ex_pkg::word_t mem_addr;
    ex_pkg::ex_mem_t ex_d;
    logic live;
    logic accept;
    logic br_flag;
    logic csr_we;
    logic csr_xchg;

    // valid instruction without exception
    assign live     = dispatch_i.instr_info.valid & ~excp_i;
    assign accept   = live & ~stall_i;
    assign csr_we   = accept & dispatch_i.csr_signal.we;
    assign csr_xchg = (dispatch_i.aluop == ex_pkg::OP_CSRXCHG);
    assign mem_addr = dispatch_i.oprand1
                    + {{20{dispatch_i.instr_info.instr[21]}}, dispatch_i.instr_info.instr[21:10]};

    ex_alu i_alu (
        .aluop_i     (dispatch_i.aluop),
        .alusel_i    (dispatch_i.alusel),
        .oprand1_i   (dispatch_i.oprand1),
        .oprand2_i   (dispatch_i.oprand2),
        .pc_i        (dispatch_i.instr_info.pc),
        .csr_rdata_i (csr_rdata),
        .wdata_o     (alu_wdata)
    );

    ex_branch i_branch (
        .en_i            (accept),
        .aluop_i         (dispatch_i.aluop),
        .pc_i            (dispatch_i.instr_info.pc),
        .imm_i           (dispatch_i.imm),
        .oprand1_i       (dispatch_i.oprand1),
        .branch_cmp_i    (dispatch_i.branch_cmp),
        .branch_flag_o   (br_flag),
        .branch_target_o (br_target)
    );

    ex_csr_file #(
        .NUM_SAVE (NUM_SAVE)
    ) i_csr_file (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .addr_i  (dispatch_i.csr_signal.addr),
        .we_i    (csr_we),
        .xchg_i  (csr_xchg),
        .wdata_i (dispatch_i.oprand2),
        .mask_i  (dispatch_i.oprand1),
        .rdata_o (csr_rdata)
    );

    always_comb begin
        ex_d                 = '0;
        ex_d.instr_info      = dispatch_i.instr_info;
        ex_d.aluop           = dispatch_i.aluop;
        ex_d.wreg            = live & dispatch_i.reg_write_valid;
        ex_d.waddr           = dispatch_i.reg_write_addr;
        ex_d.wdata           = alu_wdata;
        ex_d.mem_addr        = mem_addr;
        ex_d.reg2            = dispatch_i.oprand2;
        ex_d.csr_signal.we   = live & dispatch_i.csr_signal.we;
        ex_d.csr_signal.addr = dispatch_i.csr_signal.addr;
        ex_d.csr_signal.data = dispatch_i.oprand2;
    end

    // output register toward the memory stage
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ex_o.instr_info.valid <= 1'b0;
            ex_o.wreg             <= 1'b0;
            ex_o.csr_signal.we    <= 1'b0;
            branch_flag_o         <= 1'b0;
            excp_o                <= 1'b0;
        end else if (!stall_i) begin
            ex_o            <= ex_d;
            branch_flag_o   <= br_flag;
            branch_target_o <= br_target;
            excp_o          <= dispatch_i.instr_info.valid & excp_i;
            excp_code_o     <= {1'b0, excp_num_i};
        end
    end

    assign ex_fwd_o.wreg  = ex_o.wreg;
    assign ex_fwd_o.waddr = ex_o.waddr;
    assign ex_fwd_o.wdata = ex_o.wdata;
    assign ex_fwd_o.aluop = ex_o.aluop;

    // mem stage relies on the bundle holding while stalled
    a_stall_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stall_i |=> $stable(ex_o))
        else $error("ex_o changed after a stall cycle");

endmodule

`default_nettype wire

// ==== verif/ex_stage_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module ex_stage_tb;

    localparam int NUM_INSTR = 600;
    // 600 slots plus one stall in six is about 720 cycles
    localparam int MAX_CYCLES = 2000;

    localparam ex_pkg::alu_op_t OPS [28] = '{
        ex_pkg::OP_OR, ex_pkg::OP_AND, ex_pkg::OP_XOR, ex_pkg::OP_NOR,
        ex_pkg::OP_SLL, ex_pkg::OP_SRL, ex_pkg::OP_SRA, ex_pkg::OP_ADD,
        ex_pkg::OP_SUB, ex_pkg::OP_SLT, ex_pkg::OP_SLTU, ex_pkg::OP_MUL,
        ex_pkg::OP_MULH, ex_pkg::OP_MULHU, ex_pkg::OP_LUI, ex_pkg::OP_PCADD,
        ex_pkg::OP_B, ex_pkg::OP_BL, ex_pkg::OP_JIRL, ex_pkg::OP_BEQ,
        ex_pkg::OP_BNE, ex_pkg::OP_BLT, ex_pkg::OP_BGE, ex_pkg::OP_BLTU,
        ex_pkg::OP_BGEU, ex_pkg::OP_CSRRD, ex_pkg::OP_CSRWR, ex_pkg::OP_CSRXCHG
    };
    // last entry is a hole in the map, reads only
    localparam ex_pkg::csr_addr_t CSR_PICK [6] = '{
        ex_pkg::CSR_CRMD, ex_pkg::CSR_PRMD, ex_pkg::CSR_ERA,
        ex_pkg::CSR_SAVE0, 14'h31, 14'h32
    };

    logic clk_i = 1'b0;
    logic rst_n_i = 1'b0;
    ex_pkg::dispatch_ex_t dispatch_i = '0;
    logic excp_i = 1'b0;
    ex_pkg::excp_num_t excp_num_i = '0;
    logic stall_i = 1'b0;

    ex_pkg::ex_mem_t ex_o;
    ex_pkg::ex_fwd_t ex_fwd_o;
    logic branch_flag_o;
    ex_pkg::word_t branch_target_o;
    logic excp_o;
    ex_pkg::excp_code_t excp_code_o;

    // reference state, crmd prmd era save0 save1
    ex_pkg::word_t csr_m [5];
    logic exp_valid;
    logic exp_wreg;
    logic exp_we;
    logic exp_flag;
    logic exp_excp;
    logic loaded;
    ex_pkg::word_t exp_wdata;
    ex_pkg::word_t exp_target;
    ex_pkg::word_t exp_mem_addr;
    ex_pkg::word_t exp_reg2;
    ex_pkg::reg_addr_t exp_waddr;
    ex_pkg::excp_code_t exp_code;
    ex_pkg::instr_info_t exp_info;
    ex_pkg::alu_op_t exp_aluop;
    ex_pkg::csr_addr_t exp_csr_addr;

    int errors = 0;
    int issued = 0;
    int cycles = 0;

    ex_stage #(
        .NUM_SAVE (2)
    ) i_dut (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .dispatch_i      (dispatch_i),
        .excp_i          (excp_i),
        .excp_num_i      (excp_num_i),
        .stall_i         (stall_i),
        .ex_o            (ex_o),
        .ex_fwd_o        (ex_fwd_o),
        .branch_flag_o   (branch_flag_o),
        .branch_target_o (branch_target_o),
        .excp_o          (excp_o),
        .excp_code_o     (excp_code_o)
    );

    function automatic ex_pkg::alu_sel_t group_of(input ex_pkg::alu_op_t op);
        case (op)
            ex_pkg::OP_OR, ex_pkg::OP_AND, ex_pkg::OP_XOR,
            ex_pkg::OP_NOR:                     return ex_pkg::SEL_LOGIC;
            ex_pkg::OP_SLL, ex_pkg::OP_SRL,
            ex_pkg::OP_SRA:                     return ex_pkg::SEL_SHIFT;
            ex_pkg::OP_LUI, ex_pkg::OP_PCADD:   return ex_pkg::SEL_MOVE;
            ex_pkg::OP_ADD, ex_pkg::OP_SUB, ex_pkg::OP_SLT, ex_pkg::OP_SLTU,
            ex_pkg::OP_MUL, ex_pkg::OP_MULH,
            ex_pkg::OP_MULHU:                   return ex_pkg::SEL_ARITH;
            ex_pkg::OP_B, ex_pkg::OP_BL,
            ex_pkg::OP_JIRL:                    return ex_pkg::SEL_JUMP;
            ex_pkg::OP_CSRRD, ex_pkg::OP_CSRWR,
            ex_pkg::OP_CSRXCHG:                 return ex_pkg::SEL_CSR;
            default:                            return 3'd0;
        endcase
    endfunction

    function automatic logic branch_taken(input ex_pkg::alu_op_t op,
                                          input ex_pkg::branch_cmp_t c);
        case (op)
            ex_pkg::OP_B, ex_pkg::OP_BL, ex_pkg::OP_JIRL: return 1'b1;
            ex_pkg::OP_BEQ:  return c.eq;
            ex_pkg::OP_BNE:  return c.ne;
            ex_pkg::OP_BLT:  return c.lt;
            ex_pkg::OP_BGE:  return c.ge;
            ex_pkg::OP_BLTU: return c.ltu;
            ex_pkg::OP_BGEU: return c.geu;
            default:         return 1'b0;
        endcase
    endfunction

    function automatic int csr_index(input ex_pkg::csr_addr_t addr);
        case (addr)
            ex_pkg::CSR_CRMD:          return 0;
            ex_pkg::CSR_PRMD:          return 1;
            ex_pkg::CSR_ERA:           return 2;
            ex_pkg::CSR_SAVE0:         return 3;
            ex_pkg::CSR_SAVE0 + 14'd1: return 4;
            default:                   return -1;
        endcase
    endfunction

    function automatic ex_pkg::word_t ref_result(input ex_pkg::alu_op_t op,
            input ex_pkg::word_t a, input ex_pkg::word_t b,
            input ex_pkg::word_t pc, input ex_pkg::word_t csr_old);
        logic [63:0] sp;
        logic [63:0] up;
        // low half of a sign-extended 64-bit product is the signed product
        sp = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        up = {32'b0, a} * {32'b0, b};
        case (op)
            ex_pkg::OP_OR:    return a | b;
            ex_pkg::OP_AND:   return a & b;
            ex_pkg::OP_XOR:   return a ^ b;
            ex_pkg::OP_NOR:   return ~(a | b);
            ex_pkg::OP_SLL:   return a << b[4:0];
            ex_pkg::OP_SRL:   return a >> b[4:0];
            // negative value shifts as the inverse of its inverse
            ex_pkg::OP_SRA:   return a[31] ? ~(~a >> b[4:0]) : a >> b[4:0];
            ex_pkg::OP_ADD:   return a + b;
            ex_pkg::OP_SUB:   return a - b;
            // flipped sign bit turns signed order into unsigned order
            ex_pkg::OP_SLT:   return {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
            ex_pkg::OP_SLTU:  return {31'b0, a < b};
            ex_pkg::OP_MUL:   return sp[31:0];
            ex_pkg::OP_MULH:  return sp[63:32];
            ex_pkg::OP_MULHU: return up[63:32];
            ex_pkg::OP_LUI:   return b;
            ex_pkg::OP_PCADD: return b + pc;
            ex_pkg::OP_B, ex_pkg::OP_BL, ex_pkg::OP_JIRL: return pc + 32'd4;
            ex_pkg::OP_CSRRD, ex_pkg::OP_CSRWR, ex_pkg::OP_CSRXCHG: return csr_old;
            default:          return '0;
        endcase
    endfunction

    task automatic flag_mismatch(input string what);
        errors++;
        $display("Fail %0t: %s", $time, what);
    endtask

    task automatic new_instr();
        ex_pkg::dispatch_ex_t d;
        ex_pkg::alu_op_t op;
        logic [31:0] r;
        d = '0;
        op = OPS[int'($urandom % 28)];
        r = $urandom;
        d.instr_info.valid = r[2:0] != 3'd0;
        d.instr_info.pc = $urandom & 32'hffff_fffc;
        d.instr_info.instr = $urandom;
        d.aluop = op;
        d.alusel = group_of(op);
        d.oprand1 = $urandom;
        // equal operands now and then
        d.oprand2 = (r[5:3] == 3'd0) ? d.oprand1 : $urandom;
        d.imm = $urandom;
        d.reg_write_valid = r[6];
        d.reg_write_addr = r[11:7];
        d.branch_cmp.eq = d.oprand1 == d.oprand2;
        d.branch_cmp.ne = d.oprand1 != d.oprand2;
        d.branch_cmp.lt = $signed(d.oprand1) < $signed(d.oprand2);
        d.branch_cmp.ge = $signed(d.oprand1) >= $signed(d.oprand2);
        d.branch_cmp.ltu = d.oprand1 < d.oprand2;
        d.branch_cmp.geu = d.oprand1 >= d.oprand2;
        if (op == ex_pkg::OP_CSRWR || op == ex_pkg::OP_CSRXCHG) begin
            d.csr_signal.we = 1'b1;
            d.csr_signal.addr = CSR_PICK[int'($urandom % 5)];
        end else begin
            d.csr_signal.addr = CSR_PICK[int'($urandom % 6)];
        end
        d.csr_signal.data = d.oprand2;
        dispatch_i = d;
        excp_i = r[15:12] == 4'd0;
        excp_num_i = r[24:16];
    endtask

    initial begin
        forever #2 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("test failed");
            $finish;
        end
    end

    // expected registered outputs, one cycle behind the accept edge
    always @(posedge clk_i) begin : model
        ex_pkg::word_t old_csr;
        logic live;
        int idx;
        live = dispatch_i.instr_info.valid & ~excp_i;
        idx = csr_index(dispatch_i.csr_signal.addr);
        old_csr = (idx < 0) ? '0 : csr_m[idx];
        if (!rst_n_i) begin
            csr_m     <= '{32'h8, 32'h0, 32'h0, 32'h0, 32'h0};
            exp_valid <= 1'b0;
            exp_wreg  <= 1'b0;
            exp_we    <= 1'b0;
            exp_flag  <= 1'b0;
            exp_excp  <= 1'b0;
            loaded    <= 1'b0;
        end else if (!stall_i) begin
            exp_valid    <= dispatch_i.instr_info.valid;
            exp_wreg     <= live & dispatch_i.reg_write_valid;
            exp_we       <= live & dispatch_i.csr_signal.we;
            exp_flag     <= live & branch_taken(dispatch_i.aluop, dispatch_i.branch_cmp);
            exp_target   <= dispatch_i.imm + ((dispatch_i.aluop == ex_pkg::OP_JIRL)
                            ? dispatch_i.oprand1 : dispatch_i.instr_info.pc);
            exp_wdata    <= ref_result(dispatch_i.aluop, dispatch_i.oprand1,
                            dispatch_i.oprand2, dispatch_i.instr_info.pc, old_csr);
            exp_mem_addr <= dispatch_i.oprand1
                            + ex_pkg::word_t'($signed(dispatch_i.instr_info.instr[21:10]));
            exp_waddr    <= dispatch_i.reg_write_addr;
            exp_reg2     <= dispatch_i.oprand2;
            exp_info     <= dispatch_i.instr_info;
            exp_aluop    <= dispatch_i.aluop;
            exp_csr_addr <= dispatch_i.csr_signal.addr;
            exp_excp     <= dispatch_i.instr_info.valid & excp_i;
            exp_code     <= {1'b0, excp_num_i};
            loaded       <= 1'b1;
            if (live && dispatch_i.csr_signal.we && idx >= 0) begin
                if (dispatch_i.aluop == ex_pkg::OP_CSRXCHG) begin
                    csr_m[idx] <= (dispatch_i.oprand2 & dispatch_i.oprand1)
                                | (old_csr & ~dispatch_i.oprand1);
                end else begin
                    csr_m[idx] <= dispatch_i.oprand2;
                end
            end
        end
    end

    a_ctrl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ex_o.instr_info.valid == exp_valid && ex_o.wreg == exp_wreg
        && ex_o.csr_signal.we == exp_we)
        else flag_mismatch("valid, wreg or csr we differs from model");
    a_flag: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        branch_flag_o == exp_flag)
        else flag_mismatch("branch_flag_o differs from model");
    a_target: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        exp_flag |-> branch_target_o == exp_target)
        else flag_mismatch("branch_target_o differs from model");
    a_excp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        excp_o == exp_excp && (loaded -> excp_code_o == exp_code))
        else flag_mismatch("excp_o or excp_code_o differs from model");
    a_wdata: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        loaded |-> ex_o.wdata == exp_wdata)
        else flag_mismatch("ex_o.wdata differs from model");
    a_mem: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        loaded |-> ex_o.mem_addr == exp_mem_addr && ex_o.reg2 == exp_reg2
        && ex_o.waddr == exp_waddr)
        else flag_mismatch("mem_addr, reg2 or waddr differs from model");
    a_pass: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        loaded |-> ex_o.instr_info == exp_info && ex_o.aluop == exp_aluop
        && ex_o.csr_signal.addr == exp_csr_addr && ex_o.csr_signal.data == exp_reg2)
        else flag_mismatch("instr_info, aluop or csr request differs from model");
    a_fwd: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        loaded |-> ex_fwd_o.wreg == exp_wreg && ex_fwd_o.waddr == exp_waddr
        && ex_fwd_o.wdata == exp_wdata && ex_fwd_o.aluop == exp_aluop)
        else flag_mismatch("forwarding bundle differs from model");

    initial begin
        void'($urandom(45));
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        while (issued < NUM_INSTR) begin
            // a stalled slot keeps its instruction
            if (!stall_i) begin
                new_instr();
            end
            stall_i = ($urandom % 6) == 0;
            if (!stall_i) begin
                issued++;
            end
            @(negedge clk_i);
        end
        dispatch_i.instr_info.valid = 1'b0;
        excp_i = 1'b0;
        repeat (2) @(negedge clk_i);
        $display("checks failed: %0d, instructions issued: %0d", errors, issued);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
source/ex_pkg.sv
source/ex_alu.sv
source/ex_branch.sv
source/ex_csr_file.sv
source/ex_stage.sv
verif/ex_stage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= ex_stage_tb
FILELIST  ?= list.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when the file list or a source changes
$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
